// ==== src/soc_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// SoC bus package
// Bus widths, slave order, device ids, map sizes and the register
// layout of the device table shared by the system-bus core
//////////////////////////////////////////////////////////////////////

package soc_pkg;

	// Bus geometry, addresses are word addresses
	localparam int ARCH_BITS = 32;
	localparam int SEL_BITS  = ARCH_BITS / 8;
	localparam int ADDR_BITS = 30;

	// Slave order on the bus and in the device table
	typedef enum logic [1:0] {
		SLV_RAM,
		SLV_DEVTBL,
		SLV_INVALID
	} slave_idx_e;

	// Device ids reported by the device table
	localparam logic [ARCH_BITS-1:0] DEVID_RAM     = 32'd1;
	localparam logic [ARCH_BITS-1:0] DEVID_DEVTBL  = 32'd7;
	localparam logic [ARCH_BITS-1:0] DEVID_INVALID = 32'd0;
	localparam logic [ARCH_BITS-1:0] SOC_ID        = 32'd6;

	// Map sizes in bytes
	localparam logic [ARCH_BITS-1:0] DEVTBL_MAPSZ  = 32'h0000_1000;
	localparam logic [ARCH_BITS-1:0] INVALID_MAPSZ = 32'h0000_1000;

	// Word offsets inside the device table
	// Entry k holds its id at ENTRY0 + 2k and its map size right after
	localparam logic [ADDR_BITS-1:0] DEVTBL_REG_SOCID  = 30'd0;
	localparam logic [ADDR_BITS-1:0] DEVTBL_REG_RSTCTL = 30'd1;
	localparam logic [ADDR_BITS-1:0] DEVTBL_REG_ENTRY0 = 30'd2;

	// Reset-control register bits, both set means warm reset
	localparam int RSTCTL_WARM   = 1;
	localparam int RSTCTL_PWROFF = 0;

endpackage

// ==== src/soc_bus_if.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic link between the address decoder and one slave
//////////////////////////////////////////////////////////////////////

interface soc_bus_if
	import soc_pkg::*;
	();

	logic                 cyc;
	logic                 stb;
	logic                 we;
	logic [ADDR_BITS-1:0] adr;
	logic [ARCH_BITS-1:0] dat_w;
	logic [SEL_BITS-1:0]  sel;
	logic [ARCH_BITS-1:0] dat_r;
	logic                 ack;

	// Decoder side
	modport master (
		output cyc, stb, we, adr, dat_w, sel,
		input  dat_r, ack
	);

	// Slave side, adr is already local to the slave window
	modport slave (
		input  cyc, stb, we, adr, dat_w, sel,
		output dat_r, ack
	);

endinterface

// ==== src/bus_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// System-bus address decoder
// Routes the host Wishbone port to the RAM or the device table and
// answers every unmapped access itself as the default slave
//////////////////////////////////////////////////////////////////////

module bus_decoder
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  logic                 clk48mhz_i,
	input  logic                 sys_rst_i,

	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [ADDR_BITS-1:0] wb_adr_i,
	input  logic [ARCH_BITS-1:0] wb_dat_i,
	input  logic [SEL_BITS-1:0]  wb_sel_i,
	output logic [ARCH_BITS-1:0] wb_dat_o,
	output logic                 wb_ack_o,

	soc_bus_if.master            ram_bus,
	soc_bus_if.master            devtbl_bus
);

	// Window limits in words, RAM first and the device table right after
	localparam logic [ADDR_BITS-1:0] RAM_TOP    = ADDR_BITS'(RAM_WORDS);
	localparam logic [ADDR_BITS-1:0] DEVTBL_TOP = ADDR_BITS'(RAM_WORDS + (DEVTBL_MAPSZ >> 2));

	slave_idx_e slv;
	logic       dflt_req;
	logic       dflt_ack_q;

	always_comb begin
		if (wb_adr_i < RAM_TOP) begin
			slv = SLV_RAM;
		end else if (wb_adr_i < DEVTBL_TOP) begin
			slv = SLV_DEVTBL;
		end else begin
			slv = SLV_INVALID;
		end
	end

	// RAM request, its window starts at word 0
	assign ram_bus.cyc   = wb_cyc_i && (slv == SLV_RAM);
	assign ram_bus.stb   = wb_stb_i && (slv == SLV_RAM) && !sys_rst_i;
	assign ram_bus.we    = wb_we_i;
	assign ram_bus.adr   = wb_adr_i;
	assign ram_bus.dat_w = wb_dat_i;
	assign ram_bus.sel   = wb_sel_i;

	// Device table sees offsets relative to its own base
	assign devtbl_bus.cyc   = wb_cyc_i && (slv == SLV_DEVTBL);
	assign devtbl_bus.stb   = wb_stb_i && (slv == SLV_DEVTBL) && !sys_rst_i;
	assign devtbl_bus.we    = wb_we_i;
	assign devtbl_bus.adr   = wb_adr_i - RAM_TOP;
	assign devtbl_bus.dat_w = wb_dat_i;
	assign devtbl_bus.sel   = wb_sel_i;

	// Default slave, one cycle ack and writes dropped
	assign dflt_req = wb_cyc_i && wb_stb_i && (slv == SLV_INVALID) && !sys_rst_i;

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			dflt_ack_q <= 1'b0;
		end else begin
			dflt_ack_q <= dflt_req && !dflt_ack_q;
		end
	end

	// Response mux follows the address the master still holds
	always_comb begin
		case (slv)
			SLV_RAM: begin
				wb_dat_o = ram_bus.dat_r;
				wb_ack_o = ram_bus.ack;
			end
			SLV_DEVTBL: begin
				wb_dat_o = devtbl_bus.dat_r;
				wb_ack_o = devtbl_bus.ack;
			end
			default: begin
				wb_dat_o = '0;
				wb_ack_o = dflt_ack_q;
			end
		endcase
	end

endmodule

// ==== src/scratch_ram.sv ====
//////////////////////////////////////////////////////////////////////
// Scratch RAM slave
// Single-port word RAM with byte-lane writes and registered reads
//////////////////////////////////////////////////////////////////////

module scratch_ram
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  logic     clk48mhz_i,
	soc_bus_if.slave bus
);

	localparam int IDX_BITS = $clog2(RAM_WORDS);

	logic [ARCH_BITS-1:0] mem [RAM_WORDS];
	logic [IDX_BITS-1:0]  idx;
	logic                 req;
	logic [ARCH_BITS-1:0] rd_q;
	logic                 ack_q;

	assign idx = bus.adr[IDX_BITS-1:0];

	// A held request is taken once, the ack cycle blocks a repeat
	assign req = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge clk48mhz_i) begin
		if (req) begin
			for (int i = 0; i < SEL_BITS; i++) begin
				if (bus.we && bus.sel[i]) begin
					mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
				end
			end
			// Read returns the word as it was before this write
			rd_q <= mem[idx];
		end
	end

	// Ack drops by itself, the decoder keeps stb low during reset
	always_ff @(posedge clk48mhz_i) begin
		ack_q <= req;
	end

	assign bus.dat_r = rd_q;
	assign bus.ack   = ack_q;

endmodule

// ==== src/device_table.sv ====
//////////////////////////////////////////////////////////////////////
// Device table slave
// Read-only SoC id and per-slave id and map size, plus the software
// reset-control register that requests warm reset or power-off
//////////////////////////////////////////////////////////////////////

module device_table
	import soc_pkg::*;
#(
	parameter int RAM_WORDS = 1024
) (
	input  logic     clk48mhz_i,
	input  logic     sys_rst_i,
	soc_bus_if.slave bus,
	output logic     warm_rst_o,
	output logic     pwroff_o
);

	localparam int                   ENTRY_CNT = int'(SLV_INVALID) + 1;
	localparam logic [ADDR_BITS-1:0] ENTRY_END = ADDR_BITS'(2 * ENTRY_CNT);
	localparam logic [ARCH_BITS-1:0] RAM_MAPSZ = ARCH_BITS'(RAM_WORDS * 4);

	logic                 req;
	logic [ADDR_BITS-1:0] ent_off;
	slave_idx_e           ent;
	logic [ARCH_BITS-1:0] rd_word;
	logic [ARCH_BITS-1:0] rd_q;
	logic                 ack_q;
	logic                 rst_wr_q;
	logic [1:0]           rstctl_q;
	logic                 warm_q;
	logic                 pwroff_q;

	assign req = bus.cyc && bus.stb && !ack_q;

	// Even offset from ENTRY0 is the id, odd is the map size
	assign ent_off = bus.adr - DEVTBL_REG_ENTRY0;
	assign ent     = slave_idx_e'(ent_off[2:1]);

	always_comb begin
		rd_word = '0;
		if (bus.adr == DEVTBL_REG_SOCID) begin
			rd_word = SOC_ID;
		end else if (bus.adr == DEVTBL_REG_RSTCTL) begin
			rd_word = ARCH_BITS'(rstctl_q);
		end else if (ent_off < ENTRY_END) begin
			case (ent)
				SLV_RAM:     rd_word = ent_off[0] ? RAM_MAPSZ : DEVID_RAM;
				SLV_DEVTBL:  rd_word = ent_off[0] ? DEVTBL_MAPSZ : DEVID_DEVTBL;
				SLV_INVALID: rd_word = ent_off[0] ? INVALID_MAPSZ : DEVID_INVALID;
				default:     rd_word = '0;
			endcase
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (req) begin
			rd_q <= rd_word;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			ack_q    <= 1'b0;
			rst_wr_q <= 1'b0;
			rstctl_q <= '0;
			warm_q   <= 1'b0;
			pwroff_q <= 1'b0;
		end else begin
			ack_q    <= req;
			rst_wr_q <= req && bus.we && (bus.adr == DEVTBL_REG_RSTCTL) && bus.sel[0];
			if (req && bus.we && (bus.adr == DEVTBL_REG_RSTCTL) && bus.sel[0]) begin
				rstctl_q <= bus.dat_w[1:0];
			end
			// Requests fire in the cycle after the write is acked
			warm_q   <= ack_q && rst_wr_q && rstctl_q[RSTCTL_WARM];
			pwroff_q <= ack_q && rst_wr_q && rstctl_q[RSTCTL_PWROFF] &&
				!rstctl_q[RSTCTL_WARM];
		end
	end

	assign bus.dat_r  = rd_q;
	assign bus.ack    = ack_q;
	assign warm_rst_o = warm_q;
	assign pwroff_o   = pwroff_q;

endmodule

// ==== src/reset_sequencer.sv ====
//////////////////////////////////////////////////////////////////////
// Reset sequencer
// Power-on countdown, warm-reset restart and power-off hold that
// together form the system reset
//////////////////////////////////////////////////////////////////////

module reset_sequencer #(
	parameter int RST_CYCLES = 65535
) (
	input  logic clk48mhz_i,
	input  logic rst_p,
	input  logic warm_rst_i,
	input  logic pwroff_i,
	output logic sys_rst_o
);

	localparam int CNT_BITS = $clog2(RST_CYCLES + 2);

	// Reload one above RST_CYCLES so the release lands exactly
	// RST_CYCLES edges after the first edge with no reload
	localparam logic [CNT_BITS-1:0] CNT_LOAD = CNT_BITS'(RST_CYCLES + 1);

	logic [CNT_BITS-1:0] cnt_q;
	logic                pwroff_q;

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || warm_rst_i) begin
			cnt_q <= CNT_LOAD;
		end else if (cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Power-off stays latched until the external reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_i) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p || (cnt_q != '0) || pwroff_q;

endmodule

// ==== src/orangecrab_soc.sv ====
//////////////////////////////////////////////////////////////////////
// OrangeCrab system-bus core
// Host Wishbone port, address decoder, scratch RAM, device table
// and reset sequencer, all on the 48 MHz clock
//////////////////////////////////////////////////////////////////////

module orangecrab_soc
	import soc_pkg::*;
#(
	parameter int RAM_WORDS  = 1024,
	parameter int RST_CYCLES = 65535
) (
	input  logic                 clk48mhz_i,
	input  logic                 rst_p,

	// Host bus, the external master
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	input  logic                 wb_we_i,
	input  logic [ADDR_BITS-1:0] wb_adr_i,
	input  logic [ARCH_BITS-1:0] wb_dat_i,
	input  logic [SEL_BITS-1:0]  wb_sel_i,
	output logic [ARCH_BITS-1:0] wb_dat_o,
	output logic                 wb_ack_o,

	output logic                 sys_rst_o
);

	logic sys_rst;
	logic warm_rst;
	logic pwroff;

	soc_bus_if ram_bus ();
	soc_bus_if devtbl_bus ();

	reset_sequencer #(
		.RST_CYCLES (RST_CYCLES)
	) u_reset_sequencer (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (rst_p),
		.warm_rst_i (warm_rst),
		.pwroff_i   (pwroff),
		.sys_rst_o  (sys_rst)
	);

	bus_decoder #(
		.RAM_WORDS (RAM_WORDS)
	) u_bus_decoder (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_sel_i   (wb_sel_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.ram_bus    (ram_bus.master),
		.devtbl_bus (devtbl_bus.master)
	);

	scratch_ram #(
		.RAM_WORDS (RAM_WORDS)
	) u_scratch_ram (
		.clk48mhz_i (clk48mhz_i),
		.bus        (ram_bus.slave)
	);

	device_table #(
		.RAM_WORDS (RAM_WORDS)
	) u_device_table (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst),
		.bus        (devtbl_bus.slave),
		.warm_rst_o (warm_rst),
		.pwroff_o   (pwroff)
	);

	assign sys_rst_o = sys_rst;

endmodule

// ==== verification/tb_orangecrab_soc.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the system-bus core
// Plays Wishbone transactions from a pattern file and checks the
// reset countdown, warm reset and power-off against a RAM model
//////////////////////////////////////////////////////////////////////

module tb_orangecrab_soc
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAM_WORDS    = 1024;
	localparam int RST_CYCLES   = 20;
	localparam int RST_HOLD     = 16;
	localparam int PWROFF_WAIT  = 100;
	localparam int MAX_LINES    = 64;
	localparam int CYCLE_BUDGET = 200;
	localparam int EXTRA_CYCLES = 2000;

	localparam logic [31:0] KIND_WRITE = 32'd0;
	localparam logic [31:0] KIND_READ  = 32'd1;
	localparam logic [31:0] KIND_END   = 32'd2;
	localparam logic [31:0] EXP_SOC_ID = 32'd6;

	// Device table sits right after the RAM window
	localparam logic [ADDR_BITS-1:0] DEVTBL_BASE = ADDR_BITS'(RAM_WORDS);
	localparam logic [ADDR_BITS-1:0] RSTCTL_ADR  = ADDR_BITS'(RAM_WORDS + 1);

	logic                 clk48mhz_i = 1'b0;
	logic                 rst_p;
	logic                 wb_cyc_i;
	logic                 wb_stb_i;
	logic                 wb_we_i;
	logic [ADDR_BITS-1:0] wb_adr_i;
	logic [ARCH_BITS-1:0] wb_dat_i;
	logic [SEL_BITS-1:0]  wb_sel_i;
	logic [ARCH_BITS-1:0] wb_dat_o;
	logic                 wb_ack_o;
	logic                 sys_rst_o;

	logic [31:0] pat_mem [5*MAX_LINES];
	int          n_lines = -1;
	logic [31:0] lfsr_state = 32'h0000_0ea8;
	logic [31:0] ram_model [RAM_WORDS];
	bit          ram_touched [RAM_WORDS];

	orangecrab_soc #(
		.RAM_WORDS  (RAM_WORDS),
		.RST_CYCLES (RST_CYCLES)
	) UUT (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (rst_p),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_sel_i   (wb_sel_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.sys_rst_o  (sys_rst_o)
	);

	initial begin
		forever #4 clk48mhz_i = ~clk48mhz_i;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	// Galois LFSR with the taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = {1'b0, s[31:1]};
		if (s[0]) begin
			n = n ^ 32'h8020_0003;
		end
		return n;
	endfunction

	// Each bit taken is the one that its own LFSR step shifts out
	function automatic int take_bits(input int count);
		int val;
		val = 0;
		for (int i = 0; i < count; i++) begin
			val = (val << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return val;
	endfunction

	function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
		input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] res;
		res = old_word;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return res;
	endfunction

	// Request signals change only on the falling edge
	task automatic drive_request(input logic we, input logic [ADDR_BITS-1:0] adr,
		input logic [31:0] dat, input logic [3:0] sel);
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_dat_i = dat;
		wb_sel_i = sel;
	endtask

	task automatic release_bus();
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic wait_ack(output logic [31:0] rdata);
		@(negedge clk48mhz_i);
		while (!wb_ack_o) begin
			@(negedge clk48mhz_i);
		end
		rdata = wb_dat_o;
	endtask

	task automatic bus_access(input logic we, input logic [ADDR_BITS-1:0] adr,
		input logic [31:0] dat, input logic [3:0] sel, output logic [31:0] rdata);
		drive_request(we, adr, dat, sel);
		wait_ack(rdata);
		release_bus();
	endtask

	// Counter has just been loaded, so release comes RST_CYCLES edges later
	task automatic expect_countdown();
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(negedge clk48mhz_i);
			check_value("sys_rst_o", 32'(sys_rst_o), 32'd1);
			check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
		end
		@(negedge clk48mhz_i);
		check_value("sys_rst_o", 32'(sys_rst_o), 32'd0);
		check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
	endtask

	// External reset with a device table read held pending throughout
	task automatic reset_with_pending_read();
		logic [31:0] rdata;
		rst_p = 1'b1;
		drive_request(1'b0, DEVTBL_BASE, 32'd0, 4'hf);
		repeat (RST_HOLD) begin
			@(negedge clk48mhz_i);
			check_value("sys_rst_o", 32'(sys_rst_o), 32'd1);
			check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
		end
		rst_p = 1'b0;
		expect_countdown();
		wait_ack(rdata);
		check_value("wb_dat_o", rdata, EXP_SOC_ID);
		release_bus();
	endtask

	task automatic play_patterns();
		logic [31:0]          kind;
		logic [ADDR_BITS-1:0] adr;
		logic [31:0]          dat;
		logic [3:0]           sel;
		logic [31:0]          exp;
		logic [31:0]          rdata;
		int                   idx;
		for (int i = 0; i < n_lines; i++) begin
			kind = pat_mem[5*i];
			adr  = pat_mem[5*i+1][ADDR_BITS-1:0];
			dat  = pat_mem[5*i+2];
			sel  = pat_mem[5*i+3][3:0];
			exp  = pat_mem[5*i+4];
			idx  = int'(adr);
			if (kind == KIND_WRITE) begin
				bus_access(1'b1, adr, dat, sel, rdata);
				if (idx < RAM_WORDS) begin
					ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
					ram_touched[idx] = 1'b1;
				end
			end else if (kind == KIND_READ) begin
				bus_access(1'b0, adr, 32'd0, sel, rdata);
				check_value("wb_dat_o", rdata, exp);
				if (idx < RAM_WORDS) begin
					check_value("wb_dat_o against RAM model", rdata, ram_model[idx]);
				end
			end else begin
				abort_run($sformatf("Pattern line %0d has an unknown kind %h", i, kind));
			end
			repeat (take_bits(2)) @(negedge clk48mhz_i);
		end
	endtask

	task automatic reread_ram();
		logic [31:0] rdata;
		for (int i = 0; i < RAM_WORDS; i++) begin
			if (ram_touched[i]) begin
				bus_access(1'b0, ADDR_BITS'(i), 32'd0, 4'hf, rdata);
				check_value("wb_dat_o against RAM model", rdata, ram_model[i]);
			end
		end
	endtask

	task automatic warm_reset_scenario(input logic [31:0] ctl);
		logic [31:0] rdata;
		bus_access(1'b1, RSTCTL_ADR, ctl, 4'hf, rdata);
		while (!sys_rst_o) begin
			@(negedge clk48mhz_i);
		end
		// A RAM read held through the countdown waits for the release
		drive_request(1'b0, '0, 32'd0, 4'hf);
		expect_countdown();
		wait_ack(rdata);
		check_value("wb_dat_o against RAM model", rdata, ram_model[0]);
		release_bus();
		bus_access(1'b0, RSTCTL_ADR, 32'd0, 4'hf, rdata);
		check_value("wb_dat_o", rdata, 32'd0);
		reread_ram();
	endtask

	task automatic power_off_scenario();
		logic [31:0] rdata;
		bus_access(1'b1, RSTCTL_ADR, 32'h0000_0001, 4'hf, rdata);
		while (!sys_rst_o) begin
			@(negedge clk48mhz_i);
		end
		drive_request(1'b0, '0, 32'd0, 4'hf);
		repeat (PWROFF_WAIT) begin
			@(negedge clk48mhz_i);
			check_value("sys_rst_o", 32'(sys_rst_o), 32'd1);
			check_value("wb_ack_o", 32'(wb_ack_o), 32'd0);
		end
		reset_with_pending_read();
		reread_ram();
	endtask

	// Budget grows with the number of pattern lines
	initial begin
		int limit;
		wait (n_lines >= 0);
		limit = CYCLE_BUDGET * n_lines + EXTRA_CYCLES;
		repeat (limit) @(posedge clk48mhz_i);
		abort_run($sformatf("Timeout after %0d cycles before the tests finished", limit));
	end

	initial begin
		int lines;
		rst_p    = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		wb_sel_i = '0;
		// Entries past the file stay at the end marker
		for (int i = 0; i < 5*MAX_LINES; i++) begin
			pat_mem[i] = KIND_END;
		end
		$readmemh("verification/bus_patterns.mem", pat_mem);
		lines = 0;
		while (lines < MAX_LINES && pat_mem[5*lines] != KIND_END) begin
			lines++;
		end
		if (lines == 0) begin
			abort_run("No transactions found in verification/bus_patterns.mem");
		end
		n_lines = lines;

		reset_with_pending_read();
		play_patterns();
		warm_reset_scenario(32'h0000_0002);
		// Both bits set also acts as a warm reset
		warm_reset_scenario(32'h0000_0003);
		power_off_scenario();

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== orangecrab_soc.f ====
src/soc_pkg.sv
src/soc_bus_if.sv
src/bus_decoder.sv
src/scratch_ram.sv
src/device_table.sv
src/reset_sequencer.sv
src/orangecrab_soc.sv
verification/tb_orangecrab_soc.sv

// ==== Makefile ====
# Verilator build and run of the system-bus core testbench

TOP := tb_orangecrab_soc
BIN := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps -f orangecrab_soc.f --top-module $(TOP)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== verification/bus_patterns.mem ====
// Columns are kind, word address, write data, byte select and expected read data in hex
// Kind 0 is a write and kind 1 is a read that checks the last column
// Full-word writes and readback in the RAM window
0 00000000 11223344 f 00000000
0 00000001 a5a5a5a5 f 00000000
0 000003ff cafef00d f 00000000
1 00000000 00000000 f 11223344
1 000003ff 00000000 f cafef00d
// Partial lane writes merge into the stored words
0 00000000 eeffaabb 1 00000000
0 00000000 99887766 6 00000000
0 00000001 0000ff00 a 00000000
1 00000000 00000000 f 118877bb
1 00000001 00000000 f 00a5ffa5
// Device table SoC id and reset control, then id and map size per entry
1 00000400 00000000 f 00000006
1 00000401 00000000 f 00000000
1 00000402 00000000 f 00000001
1 00000403 00000000 f 00001000
1 00000404 00000000 f 00000007
1 00000405 00000000 f 00001000
1 00000406 00000000 f 00000000
1 00000407 00000000 f 00001000
1 00000408 00000000 f 00000000
1 000007ff 00000000 f 00000000
// Unmapped reads return zero and writes there leave the aliased RAM words alone
1 00000800 00000000 f 00000000
1 3fffffff 00000000 f 00000000
0 00000800 deadbeef f 00000000
0 00000bff 5555aaaa f 00000000
1 00000000 00000000 f 118877bb
1 000003ff 00000000 f cafef00d
